// ==== hdl/volley_pkg.sv ====
`default_nettype none

package volley_pkg;

   // ========================================================================
   // Court geometry and game rules
   // ========================================================================
   localparam int POS_W = 12;
   localparam logic [POS_W-1:0] NET_LEFT = 12'd500;
   localparam logic [POS_W-1:0] NET_RIGHT = 12'd523;
   localparam logic [POS_W-1:0] GROUND_Y = 12'd750;

   localparam int SCORE_W = 4;
   localparam logic [SCORE_W-1:0] TARGET_DEFAULT = 4'd15;

   localparam int TOUCH_W = 3;
   localparam logic [TOUCH_W-1:0] TOUCH_LIMIT = 3'd4;

   // Hold-off timer counts down from HOLDOFF_CYCLES to zero
   localparam int HOLDOFF_CYCLES = 8;
   localparam int HOLD_W = $clog2(HOLDOFF_CYCLES + 1);

   // ========================================================================
   // Game types
   // ========================================================================
   typedef enum logic {PLAYER_ONE, PLAYER_TWO} player_t;

   typedef enum logic [1:0] {SIDE_ONE, SIDE_NET, SIDE_TWO} side_t;

   typedef struct packed {logic ground; side_t side;} court_t;

   typedef struct packed {logic [TOUCH_W-1:0] count; logic over_limit;} touch_t;

   typedef struct packed {logic valid; player_t winner;} point_t;

   typedef enum logic [1:0] {SERVE_WAIT, RALLY, POINT, MATCH_OVER} judge_state_t;

endpackage

`default_nettype wire

// ==== hdl/judge_apb_pkg.sv ====
`default_nettype none

package judge_apb_pkg;

   localparam int ADDR_W = 4;
   localparam int DATA_W = 32;

   // Register map
   localparam logic [ADDR_W-1:0] REG_CTRL = 4'h0;
   localparam logic [ADDR_W-1:0] REG_STATUS = 4'h4;
   localparam logic [ADDR_W-1:0] REG_SCORE = 4'h8;

   // CTRL fields
   localparam int CTRL_RESTART_BIT = 0;
   localparam int CTRL_TARGET_LSB = 4;

   // STATUS fields
   localparam int STATUS_STATE_LSB = 0;
   localparam int STATUS_SERVER_BIT = 2;
   localparam int STATUS_WINNER_BIT = 3;

   // SCORE fields
   localparam int SCORE_P1_LSB = 0;
   localparam int SCORE_P2_LSB = 8;

   typedef struct packed {
      logic psel;
      logic penable;
      logic pwrite;
      logic [ADDR_W-1:0] paddr;
      logic [DATA_W-1:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [DATA_W-1:0] prdata;
      logic pready;
      logic pslverr;
   } apb_rsp_t;

endpackage

`default_nettype wire

// ==== hdl/court_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module court_monitor (
   input wire clk,
   input wire rst,
   input wire logic [volley_pkg::POS_W-1:0] ball_x,
   input wire logic [volley_pkg::POS_W-1:0] ball_y,
   output volley_pkg::court_t court
);

   volley_pkg::side_t side_d;
   logic ground_d;

   // Net zone includes both bounds
   always_comb begin
      if (ball_x < volley_pkg::NET_LEFT) begin
         side_d = volley_pkg::SIDE_ONE;
      end else if (ball_x > volley_pkg::NET_RIGHT) begin
         side_d = volley_pkg::SIDE_TWO;
      end else begin
         side_d = volley_pkg::SIDE_NET;
      end
   end

   assign ground_d = (ball_y >= volley_pkg::GROUND_Y);

   // The judge works on the position seen one cycle earlier
   always_ff @(posedge clk) begin
      if (rst) begin
         court.ground <= 1'b0;
         court.side <= volley_pkg::SIDE_ONE;
      end else begin
         court.ground <= ground_d;
         court.side <= side_d;
      end
   end

   // A known ball position must give a known, legal court status next cycle
   a_court_known: assert property (@(posedge clk) disable iff (rst)
      !$isunknown({ball_x, ball_y}) |=> !$isunknown(court) &&
      court.side inside {volley_pkg::SIDE_ONE, volley_pkg::SIDE_NET, volley_pkg::SIDE_TWO});

endmodule

`default_nettype wire

// ==== hdl/touch_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module touch_counter (
   input wire clk,
   input wire rst,
   input wire clear,
   input wire hit,
   input wire other_hit,
   output volley_pkg::touch_t touch
);

   logic [volley_pkg::TOUCH_W-1:0] count;
   logic [volley_pkg::HOLD_W-1:0] holdoff;
   logic accept;

   // Repeated contact inside the hold-off window is one touch
   assign accept = hit && (holdoff == '0);

   always_ff @(posedge clk) begin
      if (rst || clear || other_hit) begin
         count <= '0;
         holdoff <= '0;
      end else if (accept) begin
         if (count != volley_pkg::TOUCH_LIMIT) begin
            count <= count + 1'b1;
         end
         holdoff <= volley_pkg::HOLD_W'(volley_pkg::HOLDOFF_CYCLES);
      end else if (holdoff != '0) begin
         holdoff <= holdoff - 1'b1;
      end
   end

   assign touch.count = count;
   assign touch.over_limit = (count == volley_pkg::TOUCH_LIMIT);

   a_count_bound: assert property (@(posedge clk) disable iff (rst)
      count <= volley_pkg::TOUCH_LIMIT);

endmodule

`default_nettype wire

// ==== hdl/rally_judge.sv ====
`timescale 1ns/1ps
`default_nettype none

module rally_judge (
   input wire clk,
   input wire rst,
   input wire volley_pkg::court_t court,
   input wire logic [1:0] hit,
   input wire volley_pkg::touch_t touch_p1,
   input wire volley_pkg::touch_t touch_p2,
   input wire volley_pkg::player_t server,
   input wire match_won,
   input wire restart,
   output logic [1:0] hit_ok,
   output logic clear,
   output volley_pkg::point_t point,
   output volley_pkg::judge_state_t state,
   output logic touch_warn,
   output logic endgame
);

   logic decide;
   volley_pkg::player_t winner_d;

   // ========================================================================
   // Hit gating
   // ========================================================================
   always_comb begin
      hit_ok = 2'b00;
      if (state == volley_pkg::RALLY) begin
         hit_ok = hit;
      end else if (state == volley_pkg::SERVE_WAIT) begin
         // Only the server may open the rally
         if (server == volley_pkg::PLAYER_ONE) begin
            hit_ok = {1'b0, hit[0]};
         end else begin
            hit_ok = {hit[1], 1'b0};
         end
      end
   end

   // ========================================================================
   // Point rules
   // ========================================================================
   always_comb begin
      decide = 1'b0;
      winner_d = volley_pkg::PLAYER_ONE;
      if (touch_p1.over_limit) begin
         decide = 1'b1;
         winner_d = volley_pkg::PLAYER_TWO;
      end else if (touch_p2.over_limit) begin
         decide = 1'b1;
      end else if (court.ground) begin
         decide = 1'b1;
         case (court.side)
            volley_pkg::SIDE_ONE: winner_d = volley_pkg::PLAYER_TWO;
            volley_pkg::SIDE_TWO: winner_d = volley_pkg::PLAYER_ONE;
            // Net zone, the only nonzero count belongs to the last toucher
            default: winner_d = (touch_p1.count != '0) ? volley_pkg::PLAYER_TWO
                                                       : volley_pkg::PLAYER_ONE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rst || restart) begin
         state <= volley_pkg::SERVE_WAIT;
         point <= '0;
      end else begin
         case (state)
            volley_pkg::SERVE_WAIT: begin
               if (hit_ok != 2'b00) state <= volley_pkg::RALLY;
            end
            volley_pkg::RALLY: begin
               if (decide) begin
                  state <= volley_pkg::POINT;
                  point.valid <= 1'b1;
                  point.winner <= winner_d;
               end
            end
            volley_pkg::POINT: begin
               point.valid <= 1'b0;
               state <= match_won ? volley_pkg::MATCH_OVER : volley_pkg::SERVE_WAIT;
            end
            default: state <= volley_pkg::MATCH_OVER;
         endcase
      end
   end

   // Counters start empty whenever the judge goes back to serve_wait
   assign clear = restart || (state == volley_pkg::POINT);

   assign touch_warn = (touch_p1.count == volley_pkg::TOUCH_LIMIT - 1'b1) ||
                       (touch_p2.count == volley_pkg::TOUCH_LIMIT - 1'b1);
   assign endgame = (state == volley_pkg::MATCH_OVER);

   a_one_hitter: assert property (@(posedge clk) disable iff (rst) !(hit[0] && hit[1]));

   a_point_state: assert property (@(posedge clk) disable iff (rst)
      point.valid == (state == volley_pkg::POINT));

endmodule

`default_nettype wire

// ==== hdl/score_keeper.sv ====
`timescale 1ns/1ps
`default_nettype none

module score_keeper (
   input wire clk,
   input wire rst,
   input wire volley_pkg::point_t point,
   input wire logic [volley_pkg::SCORE_W-1:0] target,
   input wire restart,
   output logic [volley_pkg::SCORE_W-1:0] score_p1,
   output logic [volley_pkg::SCORE_W-1:0] score_p2,
   output volley_pkg::player_t server,
   output volley_pkg::player_t last_winner,
   output logic match_won
);

   logic [volley_pkg::SCORE_W-1:0] next_score;

   // Score the winner is about to reach
   assign next_score = (point.winner == volley_pkg::PLAYER_ONE) ? score_p1 + 1'b1
                                                                : score_p2 + 1'b1;

   assign match_won = point.valid && (next_score == target);

   always_ff @(posedge clk) begin
      if (rst) begin
         score_p1 <= '0;
         score_p2 <= '0;
         server <= volley_pkg::PLAYER_ONE;
         last_winner <= volley_pkg::PLAYER_ONE;
      end else if (restart) begin
         // last_winner survives a restart so software can read who took the match
         score_p1 <= '0;
         score_p2 <= '0;
         server <= volley_pkg::PLAYER_ONE;
      end else if (point.valid) begin
         server <= point.winner;
         last_winner <= point.winner;
         if (point.winner == volley_pkg::PLAYER_ONE) begin
            score_p1 <= next_score;
         end else begin
            score_p2 <= next_score;
         end
      end
   end

endmodule

`default_nettype wire

// ==== hdl/judge_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module judge_regs (
   input wire clk,
   input wire rst,
   input wire judge_apb_pkg::apb_req_t apb_req,
   output judge_apb_pkg::apb_rsp_t apb_rsp,
   input wire volley_pkg::judge_state_t state,
   input wire volley_pkg::player_t server,
   input wire volley_pkg::player_t last_winner,
   input wire logic [volley_pkg::SCORE_W-1:0] score_p1,
   input wire logic [volley_pkg::SCORE_W-1:0] score_p2,
   output logic [volley_pkg::SCORE_W-1:0] target,
   output logic restart
);

   logic access;
   logic ctrl_wr;
   logic mapped;
   logic [volley_pkg::SCORE_W-1:0] wr_target;

   assign access = apb_req.psel && apb_req.penable;
   assign ctrl_wr = access && apb_req.pwrite && (apb_req.paddr == judge_apb_pkg::REG_CTRL);
   assign mapped = apb_req.paddr inside
      {judge_apb_pkg::REG_CTRL, judge_apb_pkg::REG_STATUS, judge_apb_pkg::REG_SCORE};
   assign wr_target = apb_req.pwdata[judge_apb_pkg::CTRL_TARGET_LSB +: volley_pkg::SCORE_W];

   always_ff @(posedge clk) begin
      if (rst) begin
         target <= volley_pkg::TARGET_DEFAULT;
         restart <= 1'b0;
      end else begin
         restart <= ctrl_wr && apb_req.pwdata[judge_apb_pkg::CTRL_RESTART_BIT];
         // A target of zero is meaningless and is ignored
         if (ctrl_wr && wr_target != '0) target <= wr_target;
      end
   end

   always_comb begin
      apb_rsp.prdata = '0;
      apb_rsp.pready = 1'b1;
      apb_rsp.pslverr = access && !mapped;
      if (access && !apb_req.pwrite) begin
         case (apb_req.paddr)
            judge_apb_pkg::REG_CTRL: begin
               apb_rsp.prdata[judge_apb_pkg::CTRL_TARGET_LSB +: volley_pkg::SCORE_W] = target;
            end
            judge_apb_pkg::REG_STATUS: begin
               apb_rsp.prdata[judge_apb_pkg::STATUS_STATE_LSB +: 2] = state;
               apb_rsp.prdata[judge_apb_pkg::STATUS_SERVER_BIT] = server;
               apb_rsp.prdata[judge_apb_pkg::STATUS_WINNER_BIT] = last_winner;
            end
            judge_apb_pkg::REG_SCORE: begin
               apb_rsp.prdata[judge_apb_pkg::SCORE_P1_LSB +: volley_pkg::SCORE_W] = score_p1;
               apb_rsp.prdata[judge_apb_pkg::SCORE_P2_LSB +: volley_pkg::SCORE_W] = score_p2;
            end
            default: apb_rsp.prdata = '0;
         endcase
      end
   end

   // Access phase must follow a setup phase of the same transfer
   a_apb_setup: assert property (@(posedge clk) disable iff (rst)
      $rose(apb_req.penable) |-> apb_req.psel && $past(apb_req.psel && !apb_req.penable));

endmodule

`default_nettype wire

// ==== hdl/volley_judge_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module volley_judge_top (
   input wire clk,
   input wire rst,
   input wire logic [volley_pkg::POS_W-1:0] ball_x,
   input wire logic [volley_pkg::POS_W-1:0] ball_y,
   input wire logic [1:0] hit,
   input wire judge_apb_pkg::apb_req_t apb_req,
   output judge_apb_pkg::apb_rsp_t apb_rsp,
   output volley_pkg::point_t point,
   output logic touch_warn,
   output logic endgame
);

   volley_pkg::court_t court;
   volley_pkg::touch_t touch_p1;
   volley_pkg::touch_t touch_p2;
   volley_pkg::player_t server;
   volley_pkg::player_t last_winner;
   volley_pkg::judge_state_t state;
   logic [1:0] hit_ok;
   logic clear;
   logic match_won;
   logic restart;
   logic [volley_pkg::SCORE_W-1:0] score_p1;
   logic [volley_pkg::SCORE_W-1:0] score_p2;
   logic [volley_pkg::SCORE_W-1:0] target;

   court_monitor u_court (.clk, .rst, .ball_x, .ball_y, .court);

   // Each player's count is wiped by the opponent's accepted hit
   touch_counter u_touch_p1 (.clk, .rst, .clear, .hit(hit_ok[0]), .other_hit(hit_ok[1]),
                             .touch(touch_p1));
   touch_counter u_touch_p2 (.clk, .rst, .clear, .hit(hit_ok[1]), .other_hit(hit_ok[0]),
                             .touch(touch_p2));

   rally_judge u_judge (.clk, .rst, .court, .hit, .touch_p1, .touch_p2, .server,
                        .match_won, .restart, .hit_ok, .clear, .point, .state,
                        .touch_warn, .endgame);

   score_keeper u_score (.clk, .rst, .point, .target, .restart, .score_p1, .score_p2,
                         .server, .last_winner, .match_won);

   judge_regs u_regs (.clk, .rst, .apb_req, .apb_rsp, .state, .server, .last_winner,
                      .score_p1, .score_p2, .target, .restart);

endmodule

`default_nettype wire

// ==== bench/volley_judge_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module volley_judge_tb;

   localparam int CLK_PERIOD = 10;
   localparam int PLANNED_RALLIES = 10;
   localparam int CYCLE_LIMIT = PLANNED_RALLIES * 40 + 400;
   localparam logic [volley_pkg::POS_W-1:0] AIR_X = 12'd200;
   localparam logic [volley_pkg::POS_W-1:0] AIR_Y = 12'd100;

   logic clk;
   logic rst;
   logic [volley_pkg::POS_W-1:0] ball_x;
   logic [volley_pkg::POS_W-1:0] ball_y;
   logic [1:0] hit;
   judge_apb_pkg::apb_req_t apb_req;
   judge_apb_pkg::apb_rsp_t apb_rsp;
   volley_pkg::point_t point;
   logic touch_warn;
   logic endgame;

   int errors = 0;
   int test_errors;
   int tests_failed;
   int points_seen = 0;
   int warn_cycles = 0;
   int cycles;
   int tally_p1;
   int tally_p2;
   logic exp_server;
   logic exp_last;
   logic exp_winners[$];
   logic [31:0] lcg_state;

   volley_judge_top UUT (.clk, .rst, .ball_x, .ball_y, .hit, .apb_req, .apb_rsp, .point,
                         .touch_warn, .endgame);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      cycles = 0;
      while (cycles < CYCLE_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: the run did not end within %0d clock cycles", CYCLE_LIMIT);
      $display("STATUS: FAIL");
      $finish;
   end

   // ========================================================================
   // Reference model and helpers
   // ========================================================================
   function automatic int unsigned lcg_pick(input int unsigned range);
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return (lcg_state >> 16) % range;
   endfunction

   // Hitter i is who[i] (1 for player two), spaced gaps[4*i +: 4] cycles after the last one
   function automatic logic referee_winner(input logic [7:0] who, input logic [31:0] gaps,
                                           input int n, input logic [11:0] land_x);
      int i;
      int t;
      int last_t;
      int count;
      logic toucher;
      t = 0;
      last_t = 0;
      count = 0;
      toucher = 1'b0;
      for (i = 0; i < n; i++) begin
         t = t + int'(gaps[4*i +: 4]);
         if (count == 0 || who[i] != toucher) begin
            toucher = who[i];
            count = 1;
            last_t = t;
         end else if (t - last_t > volley_pkg::HOLDOFF_CYCLES) begin
            count++;
            last_t = t;
         end
         if (count == int'(volley_pkg::TOUCH_LIMIT)) return ~toucher;
      end
      if (land_x < volley_pkg::NET_LEFT) return 1'b1;
      if (land_x > volley_pkg::NET_RIGHT) return 1'b0;
      // Net zone, so the last toucher loses
      return ~toucher;
   endfunction

   task automatic check_value(input string name, input int got, input int expected);
      assert (got == expected) else begin
         $display("CHECK FAILED at %0t ns: %s is 0x%0h, expected 0x%0h",
                  $time, name, got, expected);
         errors++;
      end
   endtask

   task automatic start_test();
      test_errors = errors;
   endtask

   task automatic end_test(input int num, input string name);
      if (errors == test_errors) begin
         $display("test %0d %s: passed", num, name);
      end else begin
         $display("test %0d %s: failed with %0d errors", num, name, errors - test_errors);
         tests_failed++;
      end
   endtask

   // ========================================================================
   // APB transfers, entered and left on a falling edge
   // ========================================================================
   task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
      apb_req.psel = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite = 1'b1;
      apb_req.paddr = addr;
      apb_req.pwdata = data;
      @(negedge clk);
      apb_req.penable = 1'b1;
      @(negedge clk);
      apb_req = '0;
   endtask

   task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
      apb_req.psel = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite = 1'b0;
      apb_req.paddr = addr;
      apb_req.pwdata = '0;
      @(negedge clk);
      apb_req.penable = 1'b1;
      #1;
      data = apb_rsp.prdata;
      err = apb_rsp.pslverr;
      // Zero wait states, so the slave is ready in every access phase
      check_value("pready", apb_rsp.pready, 1);
      @(negedge clk);
      apb_req = '0;
   endtask

   task automatic check_scores();
      logic [31:0] data;
      logic err;
      apb_read(judge_apb_pkg::REG_SCORE, data, err);
      check_value("prdata SCORE", data, (tally_p2 << judge_apb_pkg::SCORE_P2_LSB) | tally_p1);
   endtask

   task automatic check_status(input int st);
      logic [31:0] data;
      logic err;
      apb_read(judge_apb_pkg::REG_STATUS, data, err);
      check_value("prdata STATUS", data, st | (int'(exp_server) << 2) | (int'(exp_last) << 3));
   endtask

   // ========================================================================
   // Rally stimulus
   // ========================================================================
   task automatic play_rally(input logic [7:0] who, input logic [31:0] gaps, input int n,
                             input logic [11:0] land_x);
      int start;
      int i;
      logic stop;
      logic exp_w;
      start = points_seen;
      stop = 1'b0;
      exp_w = referee_winner(who, gaps, n, land_x);
      exp_winners.push_back(exp_w);
      for (i = 0; i < n; i++) begin
         repeat (int'(gaps[4*i +: 4]) - 1) @(negedge clk);
         if (point.valid || points_seen != start) stop = 1'b1;
         if (!stop) begin
            hit = who[i] ? 2'b10 : 2'b01;
            @(negedge clk);
            hit = 2'b00;
         end
      end
      if (!point.valid && points_seen == start) begin
         ball_x = land_x;
         ball_y = volley_pkg::GROUND_Y;
      end
      wait (points_seen != start);
      @(negedge clk);
      ball_x = AIR_X;
      ball_y = AIR_Y;
      if (exp_w) begin
         tally_p2++;
      end else begin
         tally_p1++;
      end
      exp_server = exp_w;
      exp_last = exp_w;
      check_scores();
   endtask

   task automatic random_rally();
      logic [7:0] who;
      logic [31:0] gaps;
      int n;
      int i;
      n = 1 + lcg_pick(5);
      who = '0;
      gaps = '0;
      who[0] = exp_server;
      gaps[3:0] = 4'(1 + lcg_pick(3));
      for (i = 1; i < n; i++) begin
         who[i] = (lcg_pick(2) == 1);
         gaps[4*i +: 4] = 4'(1 + lcg_pick(6));
      end
      play_rally(who, gaps, n, 12'(lcg_pick(1024)));
   endtask

   // The player who does not serve tries to open the rally
   task automatic serve_out_of_turn();
      hit = exp_server ? 2'b01 : 2'b10;
      @(negedge clk);
      hit = 2'b00;
      @(negedge clk);
      check_status(int'(volley_pkg::SERVE_WAIT));
   endtask

   // ========================================================================
   // Scoreboard
   // ========================================================================
   initial begin : scoreboard
      logic exp_w;
      forever begin
         @(negedge clk);
         if (point.valid === 1'b1) begin
            assert (exp_winners.size() != 0) else begin
               $display("Error at %0t ns: a point was awarded with no rally in play", $time);
               errors++;
            end
            if (exp_winners.size() != 0) begin
               exp_w = exp_winners.pop_front();
               check_value("point.winner", point.winner, exp_w);
            end
            points_seen++;
         end
      end
   end

   always @(negedge clk) begin
      if (touch_warn === 1'b1) warn_cycles++;
   end

   // ========================================================================
   // Test sequence
   // ========================================================================
   initial begin
      logic [31:0] data;
      logic err;
      int held_points;
      int warn_before;
      rst = 1'b1;
      ball_x = AIR_X;
      ball_y = AIR_Y;
      hit = 2'b00;
      apb_req = '0;
      tests_failed = 0;
      tally_p1 = 0;
      tally_p2 = 0;
      exp_server = 1'b0;
      exp_last = 1'b0;
      lcg_state = 32'd33;
      repeat (5) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);

      start_test();
      check_value("point.valid", point.valid, 0);
      check_value("endgame", endgame, 0);
      check_value("touch_warn", touch_warn, 0);
      check_status(int'(volley_pkg::SERVE_WAIT));
      check_scores();
      apb_read(judge_apb_pkg::REG_CTRL, data, err);
      check_value("prdata CTRL", data, 32'h0000_00F0);
      end_test(1, "reset defaults");

      start_test();
      serve_out_of_turn();
      play_rally(8'b0000_0010, 32'h0000_0052, 2, 12'd100);
      check_status(int'(volley_pkg::SERVE_WAIT));
      serve_out_of_turn();
      play_rally(8'b0000_0101, 32'h0000_0642, 3, 12'd900);
      check_status(int'(volley_pkg::SERVE_WAIT));
      end_test(2, "ground contact and serve order");

      start_test();
      warn_before = warn_cycles;
      // Two close contacts fall inside hold-off, so three touches count
      play_rally(8'h00, 32'h0004_AA32, 5, 12'd900);
      assert (warn_cycles > warn_before) else begin
         $display("Error at %0t ns: touch_warn never rose after a third touch", $time);
         errors++;
      end
      play_rally(8'h00, 32'h0000_AAA2, 4, 12'd900);
      end_test(3, "touch limit and hold-off");

      start_test();
      play_rally(8'b0000_0101, 32'h0000_0552, 3, 12'd510);
      end_test(4, "net zone landing");

      start_test();
      apb_write(judge_apb_pkg::REG_CTRL, 32'h0000_0031);
      @(negedge clk);
      tally_p1 = 0;
      tally_p2 = 0;
      exp_server = 1'b0;
      check_scores();
      while (tally_p1 < 3 && tally_p2 < 3) begin
         random_rally();
      end
      check_value("endgame", endgame, 1);
      check_status(int'(volley_pkg::MATCH_OVER));
      held_points = points_seen;
      hit = exp_server ? 2'b10 : 2'b01;
      @(negedge clk);
      hit = 2'b00;
      repeat (3) @(negedge clk);
      ball_x = 12'd100;
      ball_y = volley_pkg::GROUND_Y;
      repeat (10) @(negedge clk);
      ball_x = AIR_X;
      ball_y = AIR_Y;
      check_value("points after match end", points_seen, held_points);
      apb_write(judge_apb_pkg::REG_CTRL, 32'h0000_0031);
      @(negedge clk);
      tally_p1 = 0;
      tally_p2 = 0;
      exp_server = 1'b0;
      check_value("endgame", endgame, 0);
      check_scores();
      check_status(int'(volley_pkg::SERVE_WAIT));
      end_test(5, "match end and restart");

      start_test();
      apb_read(4'hC, data, err);
      check_value("pslverr", err, 1);
      check_value("prdata unmapped", data, 0);
      apb_write(judge_apb_pkg::REG_CTRL, 32'h0000_0000);
      apb_read(judge_apb_pkg::REG_CTRL, data, err);
      check_value("pslverr", err, 0);
      check_value("prdata CTRL", data, 32'h0000_0030);
      end_test(6, "bus errors and target write");

      $display("tests run 6, tests failed %0d, checks failed %0d", tests_failed, errors);
      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== volley_judge_top.f ====
hdl/volley_pkg.sv
hdl/judge_apb_pkg.sv
hdl/court_monitor.sv
hdl/touch_counter.sv
hdl/rally_judge.sv
hdl/score_keeper.sv
hdl/judge_regs.sv
hdl/volley_judge_top.sv
bench/volley_judge_tb.sv

// ==== Bender.yml ====
package:
  name: volley_judge

sources:
  - hdl/volley_pkg.sv
  - hdl/judge_apb_pkg.sv
  - hdl/court_monitor.sv
  - hdl/touch_counter.sv
  - hdl/rally_judge.sv
  - hdl/score_keeper.sv
  - hdl/judge_regs.sv
  - hdl/volley_judge_top.sv
  - target: test
    files:
      - bench/volley_judge_tb.sv
